/* src.f */
+incdir+source
source/link_frame_pkg.sv
source/link_ctrl_pkg.sv
source/link_frame_assembler.sv
source/link_frame_tx.sv
source/link_frame_disassembler.sv
source/link_packet_dispatcher.sv
source/link_mux_top.sv
tests/link_mux_tb.sv

/* tests/link_mux_tb.sv */
`include "link_mux_macros.svh"

module link_mux_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import link_frame_pkg::*;

  localparam int NCH        = `NUM_CHANS;
  localparam int PB         = `PKT_BITS;
  localparam int CRED       = `CREDITS;
  localparam int NUM_TESTS  = 6;
  localparam int WAIT_LIMIT = 3000;
  localparam int EXP_DEPTH  = 64;

  // injection kinds
  localparam int INJ_FLIP = 1;
  localparam int INJ_KCLR = 2;
  localparam logic [PB-1:0] FLIP_MASK = 32'h0001_0000;

  // things a test can wait for
  localparam int GOAL_DRAINED  = 0;
  localparam int GOAL_INJECTED = 1;
  localparam int GOAL_CRC      = 2;
  localparam int GOAL_FRM      = 3;
  localparam int GOAL_CREDIT   = 4;

  logic               clk;
  logic               rst_n;
  logic [NCH*PB-1:0]  pkt_data;
  logic [NCH-1:0]     pkt_vld;
  logic [NCH-1:0]     pkt_rdy;
  logic [PB-1:0]      hsl_data;
  logic               hsl_kchr;
  logic               hsl_vld;
  logic               hsl_rdy;
  logic [PB-1:0]      ihsl_data;
  logic               ihsl_kchr;
  logic               ihsl_vld;
  logic [NCH*PB-1:0]  opkt_data;
  logic [NCH-1:0]     opkt_vld;
  logic [NCH-1:0]     opkt_rdy;
  logic               crc_err;
  logic               frm_err;

  // stimulus control, set by the test sequence
  int                 quota [NCH];
  int                 issued [NCH];
  int                 acc_cnt [NCH];
  logic [NCH-1:0]     hold;
  logic               slow_link;
  logic               err_ok;
  int                 inj_mode;
  int                 inj_req;
  int                 inj_hits;
  logic [31:0]        rng;

  // scoreboard, one ring per channel
  logic [PB-1:0]      exp_mem [NCH][EXP_DEPTH];
  int                 exp_head [NCH];
  int                 exp_tail [NCH];

  // link monitor state
  logic               stall_q;
  logic [PB-1:0]      held_data;
  logic               held_kchr;
  logic               want_pld;
  int                 stall_cnt;
  int                 crc_cnt;
  int                 frm_cnt;

  int                 mark;
  int                 err_cnt;
  int                 err_mark;
  int                 test_num;
  int                 pass_cnt;
  int                 fail_cnt;

  logic               inj_on;
  logic               flip_hit;
  logic               kclr_hit;

  link_mux_top link_mux_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .pkt_data  (pkt_data),
    .pkt_vld   (pkt_vld),
    .pkt_rdy   (pkt_rdy),
    .hsl_data  (hsl_data),
    .hsl_kchr  (hsl_kchr),
    .hsl_vld   (hsl_vld),
    .hsl_rdy   (hsl_rdy),
    .ihsl_data (ihsl_data),
    .ihsl_kchr (ihsl_kchr),
    .ihsl_vld  (ihsl_vld),
    .opkt_data (opkt_data),
    .opkt_vld  (opkt_vld),
    .opkt_rdy  (opkt_rdy),
    .crc_err   (crc_err),
    .frm_err   (frm_err)
  );

  // ------------------------------
  // loopback with error injection
  // ------------------------------
  // only words actually taken by the link reach the receiver
  assign inj_on    = (inj_req != inj_hits) && hsl_vld && hsl_rdy;
  assign flip_hit  = inj_on && (inj_mode == INJ_FLIP) && !hsl_kchr;
  // data headers only, credit frames pass untouched
  assign kclr_hit  = inj_on && (inj_mode == INJ_KCLR) && hsl_kchr
                  && (hsl_data[PB-1 -: 2] == FRM_DATA);
  assign ihsl_data = flip_hit ? (hsl_data ^ FLIP_MASK) : hsl_data;
  assign ihsl_kchr = hsl_kchr && !kclr_hit;
  assign ihsl_vld  = hsl_vld && hsl_rdy;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
    err_cnt++;
  endtask

  task automatic report_failure(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  // ------------------------------
  // input driver
  // ------------------------------
  always @(posedge clk) begin : drive_inputs
    logic hs;
    if (rst_n) begin
      rng = lcg_next(rng);
      hsl_rdy <= slow_link ? rng[16] : (rng[17:16] != 2'b00);
      for (int i = 0; i < NCH; i++) begin
        opkt_rdy[i] <= !hold[i] && rng[20 + i];
      end
      for (int i = 0; i < NCH; i++) begin
        hs = pkt_vld[i] && pkt_rdy[i];
        // every accepted packet is owed at the output
        if (hs) begin
          exp_mem[i][exp_tail[i] % EXP_DEPTH] = pkt_data[i*PB +: PB];
          exp_tail[i] = exp_tail[i] + 1;
          acc_cnt[i] <= acc_cnt[i] + 1;
        end
        if ((!pkt_vld[i] || hs) && (issued[i] != quota[i])) begin
          rng = lcg_next(rng);
          pkt_data[i*PB +: PB] <= rng;
          pkt_vld[i]           <= 1'b1;
          issued[i]            <= issued[i] + 1;
        end else if (hs) begin
          pkt_vld[i] <= 1'b0;
        end
      end
    end
  end

  // ------------------------------
  // link and output checks
  // ------------------------------
  always @(posedge clk) begin : check_outputs
    if (!rst_n) begin
      stall_q  <= 1'b0;
      want_pld <= 1'b0;
    end else begin
      // word frozen while the link stalls
      if (stall_q) begin
        assert (hsl_data == held_data) else report_mismatch("hsl_data", hsl_data, held_data);
        assert (hsl_kchr == held_kchr) else report_mismatch("hsl_kchr", hsl_kchr, held_kchr);
      end
      stall_q   <= hsl_vld && !hsl_rdy;
      held_data <= hsl_data;
      held_kchr <= hsl_kchr;
      if (hsl_vld && !hsl_rdy) begin
        stall_cnt <= stall_cnt + 1;
      end
      // headers carry k, the payload after a data header does not
      if (hsl_vld && hsl_rdy) begin
        assert (hsl_kchr == !want_pld) else report_mismatch("hsl_kchr", hsl_kchr, !want_pld);
        want_pld <= hsl_kchr && (hsl_data[PB-1 -: 2] == FRM_DATA);
      end
      if (flip_hit || kclr_hit) begin
        inj_hits <= inj_hits + 1;
      end
      if (crc_err) begin
        crc_cnt <= crc_cnt + 1;
      end
      if (frm_err) begin
        frm_cnt <= frm_cnt + 1;
      end
      if (!err_ok) begin
        assert (!crc_err) else report_failure("crc_err pulsed with no error injected");
        assert (!frm_err) else report_failure("frm_err pulsed with no error injected");
      end
      // same channel, same order, same data
      for (int i = 0; i < NCH; i++) begin
        if (opkt_vld[i] && opkt_rdy[i]) begin
          if (exp_head[i] == exp_tail[i]) begin
            report_failure($sformatf("channel %0d delivered a packet never sent", i));
          end else begin
            assert (opkt_data[i*PB +: PB] == exp_mem[i][exp_head[i] % EXP_DEPTH])
              else report_mismatch($sformatf("opkt_data[%0d]", i), opkt_data[i*PB +: PB],
                                   exp_mem[i][exp_head[i] % EXP_DEPTH]);
            exp_head[i] = exp_head[i] + 1;
          end
        end
      end
    end
  end

  // ------------------------------
  // sequence helpers
  // ------------------------------
  function automatic bit drained(input int skip);
    for (int i = 0; i < NCH; i++) begin
      if (i != skip) begin
        if (issued[i] != quota[i] || pkt_vld[i] || exp_tail[i] != exp_head[i]) begin
          return 1'b0;
        end
      end
    end
    return 1'b1;
  endfunction

  function automatic bit goal_met(input int goal, input int c);
    case (goal)
      GOAL_DRAINED:  return drained(c);
      GOAL_INJECTED: return inj_hits == inj_req;
      GOAL_CRC:      return crc_cnt != mark;
      GOAL_FRM:      return frm_cnt != mark;
      GOAL_CREDIT:   return ((acc_cnt[c] - mark) >= CRED) && drained(c);
      default:       return 1'b1;
    endcase
  endfunction

  task automatic wait_goal(input int goal, input int c, input string what);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!goal_met(goal, c) && n < WAIT_LIMIT);
    if (!goal_met(goal, c)) begin
      report_failure({"timed out waiting for ", what});
    end
  endtask

  task automatic add_packets(input int c, input int n);
    quota[c] <= quota[c] + n;
  endtask

  task automatic add_all(input int n);
    for (int i = 0; i < NCH; i++) begin
      add_packets(i, n);
    end
  endtask

  task automatic finish_test(input string name);
    test_num++;
    if (err_cnt == err_mark) begin
      pass_cnt++;
      $display("test %0d %s: passed", test_num, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: failed with %0d errors", test_num, name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  // stalled output, so the channel stops after its credits run out
  task automatic check_credit_limit(input int c);
    mark = acc_cnt[c];
    hold[c] <= 1'b1;
    add_packets(c, CRED + 2);
    wait_goal(GOAL_CREDIT, c, "credit exhaustion");
    repeat (100) begin
      @(posedge clk);
      assert (!pkt_rdy[c]) else report_failure($sformatf("pkt_rdy[%0d] high with no credit", c));
    end
    assert (acc_cnt[c] - mark == CRED)
      else report_mismatch($sformatf("accepted on channel %0d", c), acc_cnt[c] - mark, CRED);
    hold[c] <= 1'b0;
    wait_goal(GOAL_DRAINED, NCH, "traffic to drain");
  endtask

  // one damaged frame on an otherwise quiet link
  task automatic inject_error(input int mode, input int c);
    int crc0;
    int frm0;
    crc0 = crc_cnt;
    frm0 = frm_cnt;
    mark = (mode == INJ_FLIP) ? crc_cnt : frm_cnt;
    err_ok   <= 1'b1;
    inj_mode <= mode;
    inj_req  <= inj_req + 1;
    add_packets(c, 1);
    wait_goal(GOAL_INJECTED, c, "the injected word");
    wait_goal((mode == INJ_FLIP) ? GOAL_CRC : GOAL_FRM, c, "an error pulse");
    // late pulses or a stray delivery would land in this window
    repeat (50) @(posedge clk);
    if (mode == INJ_FLIP) begin
      assert (crc_cnt - crc0 == 1) else report_mismatch("crc_err pulses", crc_cnt - crc0, 1);
      assert (frm_cnt == frm0) else report_failure("frm_err pulsed on a payload bit error");
    end else begin
      assert (frm_cnt != frm0) else report_failure("no frm_err after a header lost its k-flag");
      assert (crc_cnt == crc0) else report_failure("crc_err pulsed on a framing error");
    end
    assert (exp_tail[c] - exp_head[c] == 1)
      else report_mismatch($sformatf("packets owed on channel %0d", c),
                           exp_tail[c] - exp_head[c], 1);
    // the damaged packet is gone for good
    exp_head[c] = exp_tail[c];
    err_ok <= 1'b0;
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    rst_n     = 1'b0;
    pkt_data  = '0;
    pkt_vld   = '0;
    hsl_rdy   = 1'b0;
    opkt_rdy  = '0;
    hold      = '0;
    slow_link = 1'b0;
    err_ok    = 1'b0;
    inj_mode  = 0;
    inj_req   = 0;
    rng       = 32'hea87_f248;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    repeat (2) begin
      @(posedge clk);
      assert (pkt_rdy == '0) else report_mismatch("pkt_rdy", pkt_rdy, 0);
      assert (!hsl_vld) else report_mismatch("hsl_vld", hsl_vld, 0);
      assert (opkt_vld == '0) else report_mismatch("opkt_vld", opkt_vld, 0);
      assert (!crc_err) else report_mismatch("crc_err", crc_err, 0);
      assert (!frm_err) else report_mismatch("frm_err", frm_err, 0);
    end
    finish_test("reset state");

    add_all(20);
    wait_goal(GOAL_DRAINED, NCH, "traffic to drain");
    finish_test("random traffic on all channels");

    // other channels keep flowing while channel 0 is blocked
    for (int i = 1; i < NCH; i++) begin
      add_packets(i, 12);
    end
    check_credit_limit(0);
    finish_test("credit limit with a blocked output");

    mark = stall_cnt;
    slow_link <= 1'b1;
    add_all(10);
    wait_goal(GOAL_DRAINED, NCH, "traffic to drain");
    slow_link <= 1'b0;
    assert (stall_cnt != mark) else report_failure("no link stall was seen");
    finish_test("link back-pressure");

    inject_error(INJ_FLIP, 1);
    check_credit_limit(1);
    finish_test("payload bit error");

    inject_error(INJ_KCLR, 2);
    add_all(8);
    wait_goal(GOAL_DRAINED, NCH, "traffic to drain");
    finish_test("lost k-flag and recovery");

    $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // bound on the whole run
  initial begin : watchdog
    #(NUM_TESTS * 2000 * 8);
    $display("watchdog expired after %0d ns, the run did not finish", NUM_TESTS * 2000 * 8);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* source/link_mux_top.sv */
`include "link_mux_macros.svh"

module link_mux_top (
  input  logic                             clk,
  input  logic                             rst_n,

  // packet inputs
  input  logic [`NUM_CHANS*`PKT_BITS-1:0]  pkt_data,
  input  logic [`NUM_CHANS-1:0]            pkt_vld,
  output logic [`NUM_CHANS-1:0]            pkt_rdy,

  // outgoing link
  output logic [`PKT_BITS-1:0]             hsl_data,
  output logic                             hsl_kchr,
  output logic                             hsl_vld,
  input  logic                             hsl_rdy,

  // incoming link
  input  logic [`PKT_BITS-1:0]             ihsl_data,
  input  logic                             ihsl_kchr,
  input  logic                             ihsl_vld,

  // packet outputs
  output logic [`NUM_CHANS*`PKT_BITS-1:0]  opkt_data,
  output logic [`NUM_CHANS-1:0]            opkt_vld,
  input  logic [`NUM_CHANS-1:0]            opkt_rdy,

  // status
  output logic                             crc_err,
  output logic                             frm_err
);

  // ------------------------------
  // internal wiring
  // ------------------------------
  // assembler to transmitter
  logic [`PKT_BITS-1:0]   frm_hdr;
  logic [`PKT_BITS-1:0]   frm_pld;
  logic                   frm_vld;
  logic                   frm_rdy;

  // dispatcher to transmitter
  logic [`CHAN_BITS-1:0]  cr_chan;
  logic                   cr_vld;
  logic                   cr_rdy;

  // disassembler to assembler
  logic [`CHAN_BITS-1:0]  rcr_chan;
  logic                   rcr_vld;

  // disassembler to dispatcher
  logic [`CHAN_BITS-1:0]  rpkt_chan;
  logic [`PKT_BITS-1:0]   rpkt_data;
  logic                   rpkt_vld;
  logic [`CHAN_BITS-1:0]  drop_chan;
  logic                   drop_vld;

  // transmit side
  link_frame_assembler frame_assembler_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .rcr_chan (rcr_chan),
    .rcr_vld  (rcr_vld),
    .frm_hdr  (frm_hdr),
    .frm_pld  (frm_pld),
    .frm_vld  (frm_vld),
    .frm_rdy  (frm_rdy)
  );

  link_frame_tx frame_tx_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .frm_hdr  (frm_hdr),
    .frm_pld  (frm_pld),
    .frm_vld  (frm_vld),
    .frm_rdy  (frm_rdy),
    .cr_chan  (cr_chan),
    .cr_vld   (cr_vld),
    .cr_rdy   (cr_rdy),
    .hsl_data (hsl_data),
    .hsl_kchr (hsl_kchr),
    .hsl_vld  (hsl_vld),
    .hsl_rdy  (hsl_rdy)
  );

  // receive side
  link_frame_disassembler frame_disassembler_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .ihsl_data (ihsl_data),
    .ihsl_kchr (ihsl_kchr),
    .ihsl_vld  (ihsl_vld),
    .rcr_chan  (rcr_chan),
    .rcr_vld   (rcr_vld),
    .rpkt_chan (rpkt_chan),
    .rpkt_data (rpkt_data),
    .rpkt_vld  (rpkt_vld),
    .drop_chan (drop_chan),
    .drop_vld  (drop_vld),
    .crc_err   (crc_err),
    .frm_err   (frm_err)
  );

  link_packet_dispatcher packet_dispatcher_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .rpkt_chan (rpkt_chan),
    .rpkt_data (rpkt_data),
    .rpkt_vld  (rpkt_vld),
    .drop_chan (drop_chan),
    .drop_vld  (drop_vld),
    .cr_chan   (cr_chan),
    .cr_vld    (cr_vld),
    .cr_rdy    (cr_rdy),
    .opkt_data (opkt_data),
    .opkt_vld  (opkt_vld),
    .opkt_rdy  (opkt_rdy)
  );

endmodule

/* source/link_packet_dispatcher.sv */
`include "link_mux_macros.svh"

module link_packet_dispatcher (
  input  logic                             clk,
  input  logic                             rst_n,

  // packets and discards from the disassembler
  input  logic [`CHAN_BITS-1:0]            rpkt_chan,
  input  logic [`PKT_BITS-1:0]             rpkt_data,
  input  logic                             rpkt_vld,
  input  logic [`CHAN_BITS-1:0]            drop_chan,
  input  logic                             drop_vld,

  // credit return requests to the transmitter
  output logic [`CHAN_BITS-1:0]            cr_chan,
  output logic                             cr_vld,
  input  logic                             cr_rdy,

  // packet outputs, channel i in slice i
  output logic [`NUM_CHANS*`PKT_BITS-1:0]  opkt_data,
  output logic [`NUM_CHANS-1:0]            opkt_vld,
  input  logic [`NUM_CHANS-1:0]            opkt_rdy
);

  localparam int CW  = `CRED_BITS;
  localparam int CHW = `CHAN_BITS;
  localparam int PW  = $clog2(`CREDITS);

  logic [`NUM_CHANS-1:0]  pop;
  // credits owed back to the far end, per channel
  logic [CW-1:0]          ret [`NUM_CHANS];
  logic [`NUM_CHANS-1:0]  ret_nz;
  logic [CHW-1:0]         cr_ptr;

  // ------------------------------
  // receive queues
  // ------------------------------
  for (genvar i = 0; i < `NUM_CHANS; i++) begin : g_chan
    logic [`PKT_BITS-1:0]  mem [`CREDITS];
    logic [PW-1:0]         wr_ptr;
    logic [PW-1:0]         rd_ptr;
    logic [CW-1:0]         fill;
    logic                  push;

    // credits bound the sender, so a push never finds the queue full
    assign push   = rpkt_vld && (rpkt_chan == i);
    assign pop[i] = opkt_vld[i] && opkt_rdy[i];

    assign opkt_vld[i] = (fill != '0);
    assign opkt_data[i*`PKT_BITS +: `PKT_BITS] = mem[rd_ptr];
    assign ret_nz[i]   = (ret[i] != '0);

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        fill   <= '0;
      end else begin
        if (push) begin
          wr_ptr <= (wr_ptr == PW'(`CREDITS - 1)) ? '0 : wr_ptr + PW'(1);
        end
        if (pop[i]) begin
          rd_ptr <= (rd_ptr == PW'(`CREDITS - 1)) ? '0 : rd_ptr + PW'(1);
        end
        fill <= fill + CW'(push) - CW'(pop[i]);
      end
    end

    always_ff @(posedge clk) begin
      if (push) begin
        mem[wr_ptr] <= rpkt_data;
      end
    end
  end

  // ------------------------------
  // credit return
  // ------------------------------
  // rotating search from cr_ptr for a channel that is owed credit
  always_comb begin
    logic [CHW-1:0] idx;
    cr_chan = cr_ptr;
    cr_vld  = 1'b0;
    for (int k = 0; k < `NUM_CHANS; k++) begin
      idx = cr_ptr + CHW'(k);
      if (!cr_vld && ret_nz[idx]) begin
        cr_chan = idx;
        cr_vld  = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_CHANS; i++) begin
        ret[i] <= '0;
      end
      cr_ptr <= '0;
    end else begin
      // pop and drop of one channel can land together
      for (int i = 0; i < `NUM_CHANS; i++) begin
        ret[i] <= ret[i] + CW'(pop[i]) + CW'(drop_vld && (drop_chan == i))
                         - CW'(cr_vld && cr_rdy && (cr_chan == i));
      end
      if (cr_vld && cr_rdy) begin
        cr_ptr <= cr_chan + CHW'(1);
      end
    end
  end

endmodule

/* source/link_frame_disassembler.sv */
`include "link_mux_macros.svh"

module link_frame_disassembler (
  input  logic                   clk,
  input  logic                   rst_n,

  // incoming link, never stalled
  input  logic [`PKT_BITS-1:0]   ihsl_data,
  input  logic                   ihsl_kchr,
  input  logic                   ihsl_vld,

  // received credits to the assembler
  output logic [`CHAN_BITS-1:0]  rcr_chan,
  output logic                   rcr_vld,

  // packets and discards to the dispatcher
  output logic [`CHAN_BITS-1:0]  rpkt_chan,
  output logic [`PKT_BITS-1:0]   rpkt_data,
  output logic                   rpkt_vld,
  output logic [`CHAN_BITS-1:0]  drop_chan,
  output logic                   drop_vld,

  // status pulses
  output logic                   crc_err,
  output logic                   frm_err
);

  import link_frame_pkg::*;
  import link_ctrl_pkg::*;

  rx_state_t               state;

  // header fields of the current word
  logic [KIND_BITS-1:0]    hdr_kind;
  logic [`CHAN_BITS-1:0]   hdr_chan;
  logic [`CSUM_BITS-1:0]   hdr_csum;
  logic                    is_hdr;
  logic                    is_pld;
  logic                    kind_ok;

  // packet in flight between header and payload
  logic [`CHAN_BITS-1:0]   pend_chan;
  logic [`CSUM_BITS-1:0]   pend_csum;

  // ------------------------------
  // word decode
  // ------------------------------
  assign hdr_kind = ihsl_data[KIND_LSB +: KIND_BITS];
  assign hdr_chan = ihsl_data[CHAN_LSB +: `CHAN_BITS];
  assign hdr_csum = ihsl_data[`CSUM_BITS-1:0];
  assign is_hdr   = ihsl_vld && ihsl_kchr;
  assign is_pld   = ihsl_vld && !ihsl_kchr;
  assign kind_ok  = (hdr_kind == FRM_DATA) || (hdr_kind == FRM_CREDIT);

  // ------------------------------
  // receive FSM
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= RX_HDR;
      rcr_vld  <= 1'b0;
      rpkt_vld <= 1'b0;
      drop_vld <= 1'b0;
      crc_err  <= 1'b0;
      frm_err  <= 1'b0;
    end else begin
      rcr_vld  <= is_hdr && (hdr_kind == FRM_CREDIT);
      rpkt_vld <= 1'b0;
      drop_vld <= 1'b0;
      crc_err  <= 1'b0;
      // bad kind, stray payload, or header cutting a frame short
      frm_err  <= (is_hdr && !kind_ok)
               || (is_pld && (state == RX_HDR))
               || (is_hdr && (state == RX_PLD));

      // any k word is parsed as a header, whatever the state
      if (is_hdr) begin
        state <= (hdr_kind == FRM_DATA) ? RX_PLD : RX_HDR;
        if (state == RX_PLD) begin
          // interrupted frame, hand its credit back
          drop_vld <= 1'b1;
        end
      end else if (is_pld && (state == RX_PLD)) begin
        state <= RX_HDR;
        if (pld_csum(ihsl_data) == pend_csum) begin
          rpkt_vld <= 1'b1;
        end else begin
          crc_err  <= 1'b1;
          drop_vld <= 1'b1;
        end
      end
    end
  end

  // field capture
  always_ff @(posedge clk) begin
    if (is_hdr && (hdr_kind == FRM_CREDIT)) begin
      rcr_chan <= hdr_chan;
    end
    if (is_hdr && (hdr_kind == FRM_DATA)) begin
      pend_chan <= hdr_chan;
      pend_csum <= hdr_csum;
    end
    // old pend_chan, also right for a drop on a new header
    if (ihsl_vld && (state == RX_PLD)) begin
      rpkt_chan <= pend_chan;
      rpkt_data <= ihsl_data;
      drop_chan <= pend_chan;
    end
  end

endmodule

/* source/link_frame_tx.sv */
`include "link_mux_macros.svh"

module link_frame_tx (
  input  logic                   clk,
  input  logic                   rst_n,

  // data frames from the assembler
  input  logic [`PKT_BITS-1:0]   frm_hdr,
  input  logic [`PKT_BITS-1:0]   frm_pld,
  input  logic                   frm_vld,
  output logic                   frm_rdy,

  // credit return requests from the dispatcher
  input  logic [`CHAN_BITS-1:0]  cr_chan,
  input  logic                   cr_vld,
  output logic                   cr_rdy,

  // outgoing link
  output logic [`PKT_BITS-1:0]   hsl_data,
  output logic                   hsl_kchr,
  output logic                   hsl_vld,
  input  logic                   hsl_rdy
);

  import link_frame_pkg::*;
  import link_ctrl_pkg::*;

  tx_state_t             state;
  // payload held while its header is on the link
  logic [`PKT_BITS-1:0]  pld_q;
  logic                  out_free;

  // ------------------------------
  // handshakes
  // ------------------------------
  // output word register empty or being taken
  assign out_free = !hsl_vld || hsl_rdy;

  // credit frames win the header slot
  assign cr_rdy  = (state == TX_IDLE) && out_free;
  assign frm_rdy = cr_rdy && !cr_vld;

  // ------------------------------
  // link FSM
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= TX_IDLE;
      hsl_vld <= 1'b0;
    end else if (out_free) begin
      case (state)
        TX_IDLE: begin
          hsl_vld <= cr_vld || frm_vld;
          if (frm_vld && frm_rdy) begin
            state <= TX_PLD;
          end
        end
        TX_PLD: begin
          hsl_vld <= 1'b1;
          state   <= TX_IDLE;
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // word on the link, frozen while hsl_rdy is low
  always_ff @(posedge clk) begin
    if (out_free) begin
      if (state == TX_PLD) begin
        hsl_data <= pld_q;
        hsl_kchr <= 1'b0;
      end else if (cr_vld) begin
        // credit frame is a lone header, checksum zero
        hsl_data <= make_hdr(FRM_CREDIT, cr_chan, '0);
        hsl_kchr <= 1'b1;
      end else begin
        hsl_data <= frm_hdr;
        hsl_kchr <= 1'b1;
      end
    end
    if (frm_vld && frm_rdy) begin
      pld_q <= frm_pld;
    end
  end

endmodule

/* source/link_frame_assembler.sv */
`include "link_mux_macros.svh"

module link_frame_assembler (
  input  logic                             clk,
  input  logic                             rst_n,

  // packet inputs, channel i in slice i
  input  logic [`NUM_CHANS*`PKT_BITS-1:0]  pkt_data,
  input  logic [`NUM_CHANS-1:0]            pkt_vld,
  output logic [`NUM_CHANS-1:0]            pkt_rdy,

  // credits returned by the far end
  input  logic [`CHAN_BITS-1:0]            rcr_chan,
  input  logic                             rcr_vld,

  // frame buffer towards the transmitter
  output logic [`PKT_BITS-1:0]             frm_hdr,
  output logic [`PKT_BITS-1:0]             frm_pld,
  output logic                             frm_vld,
  input  logic                             frm_rdy
);

  import link_frame_pkg::*;

  localparam int CW  = `CRED_BITS;
  localparam int CHW = `CHAN_BITS;
  localparam logic [CW-1:0] CRED_INIT = CW'(`CREDITS);

  // per-channel transmit credits
  logic [CW-1:0]          cred [`NUM_CHANS];
  logic [`NUM_CHANS-1:0]  elig;

  // round-robin state and current pick
  logic [CHW-1:0]         rr_ptr;
  logic [CHW-1:0]         grant_chan;
  logic                   grant_any;

  logic                   buf_free;
  logic                   take;
  logic [`PKT_BITS-1:0]   sel_data;

  // ------------------------------
  // channel choice
  // ------------------------------
  // a channel competes only with a packet waiting and credit left
  always_comb begin
    for (int i = 0; i < `NUM_CHANS; i++) begin
      elig[i] = pkt_vld[i] && (cred[i] != '0);
    end
  end

  // first eligible channel at or after rr_ptr
  always_comb begin
    logic [CHW-1:0] idx;
    grant_chan = rr_ptr;
    grant_any  = 1'b0;
    for (int k = 0; k < `NUM_CHANS; k++) begin
      idx = rr_ptr + CHW'(k);
      if (!grant_any && elig[idx]) begin
        grant_chan = idx;
        grant_any  = 1'b1;
      end
    end
  end

  // buffer can load when empty or emptying this cycle
  assign buf_free = !frm_vld || frm_rdy;
  assign take     = grant_any && buf_free;
  assign sel_data = pkt_data[grant_chan*`PKT_BITS +: `PKT_BITS];

  // only the granted channel sees ready
  always_comb begin
    for (int i = 0; i < `NUM_CHANS; i++) begin
      pkt_rdy[i] = take && (grant_chan == i);
    end
  end

  // ------------------------------
  // credits and frame buffer
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_CHANS; i++) begin
        cred[i] <= CRED_INIT;
      end
      rr_ptr  <= '0;
      frm_vld <= 1'b0;
    end else begin
      // return and spend may coincide
      for (int i = 0; i < `NUM_CHANS; i++) begin
        cred[i] <= cred[i] + CW'(rcr_vld && (rcr_chan == i))
                           - CW'(pkt_vld[i] && pkt_rdy[i]);
      end
      if (take) begin
        frm_vld <= 1'b1;
        // next search starts past the winner
        rr_ptr  <= grant_chan + CHW'(1);
      end else if (frm_rdy) begin
        frm_vld <= 1'b0;
      end
    end
  end

  // frame contents
  always_ff @(posedge clk) begin
    if (take) begin
      frm_pld <= sel_data;
      frm_hdr <= make_hdr(FRM_DATA, grant_chan, pld_csum(sel_data));
    end
  end

endmodule

/* source/link_ctrl_pkg.sv */
package link_ctrl_pkg;

  // ------------------------------
  // protocol engine states
  // ------------------------------

  // transmitter: header slot or payload slot
  typedef enum logic {
    TX_IDLE,
    TX_PLD
  } tx_state_t;

  // disassembler: waiting for header or for payload
  typedef enum logic {
    RX_HDR,
    RX_PLD
  } rx_state_t;

endpackage

/* source/link_frame_pkg.sv */
`include "link_mux_macros.svh"

package link_frame_pkg;

  // ------------------------------
  // header field layout
  // ------------------------------
  // kind in the top bits, channel just below, checksum at the bottom
  localparam int KIND_BITS = 2;
  localparam int KIND_LSB  = `PKT_BITS - KIND_BITS;
  localparam int CHAN_LSB  = KIND_LSB - `CHAN_BITS;

  // frame kinds, all-zero kind left unused so a blank word is never a header
  typedef enum logic [KIND_BITS-1:0] {
    FRM_DATA   = 2'b01,
    FRM_CREDIT = 2'b10
  } frame_kind_t;

  // xor of the payload bytes
  function automatic logic [`CSUM_BITS-1:0] pld_csum(input logic [`PKT_BITS-1:0] pld);
    logic [`CSUM_BITS-1:0] acc;
    acc = '0;
    for (int b = 0; b < `PKT_BITS / `CSUM_BITS; b++) begin
      acc ^= pld[b*`CSUM_BITS +: `CSUM_BITS];
    end
    return acc;
  endfunction

  // build a header word, unused bits stay zero
  function automatic logic [`PKT_BITS-1:0] make_hdr(
    input frame_kind_t           kind,
    input logic [`CHAN_BITS-1:0] chan,
    input logic [`CSUM_BITS-1:0] csum
  );
    logic [`PKT_BITS-1:0] hdr;
    hdr = '0;
    hdr[KIND_LSB +: KIND_BITS]  = kind;
    hdr[CHAN_LSB +: `CHAN_BITS] = chan;
    hdr[`CSUM_BITS-1:0]         = csum;
    return hdr;
  endfunction

endpackage

/* source/link_mux_macros.svh */
`ifndef LINK_MUX_MACROS_SVH
`define LINK_MUX_MACROS_SVH

// ------------------------------
// link multiplexer sizes
// ------------------------------

// channels sharing the link
`define NUM_CHANS 4
// channel index width
`define CHAN_BITS 2

// packet width, same as the link word
`define PKT_BITS 32

// receive queue depth per channel, also the initial transmit credit
`define CREDITS 4
// credit counter width, must hold CREDITS itself
`define CRED_BITS 3

// header checksum, xor of the payload bytes
`define CSUM_BITS 8

`endif
